// ==== soc_pkg.sv ====
package soc_pkg;

  // bus word and strobe widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // seven-segment pattern, active low, segment a in bit 0
  typedef logic [6:0]  seg_t;

  typedef logic [17:0] led_t;
  typedef logic [17:0] sw_t;

  localparam int RAM_WORDS = 256;
  typedef logic [$clog2(RAM_WORDS)-1:0] ram_index_t;
  typedef logic [1:0] io_index_t;

  // ram window 0x0000_0000 to 0x0000_03ff
  localparam addr_t RAM_BASE = 32'h0000_0000;
  localparam addr_t RAM_MASK = 32'h0000_03ff;

  // io window 0x0001_0000 to 0x0001_000f
  localparam addr_t IO_BASE  = 32'h0001_0000;
  localparam addr_t IO_MASK  = 32'h0000_000f;

  // io register indexes
  localparam io_index_t IO_LED = 2'd0;
  localparam io_index_t IO_SW  = 2'd1;

  typedef enum logic [1:0] {
    cs_none,
    cs_ram,
    cs_io
  } cs_e;

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_capture,
    st_done
  } bus_state_e;

endpackage

// ==== scratch_ram.sv ====
`timescale 1ns/10ps

module scratch_ram (
  input  logic           clock_50,
  input  logic           ram_read,
  input  logic           ram_write,
  input  soc_pkg::addr_t address,
  input  soc_pkg::data_t writedata,
  input  soc_pkg::be_t   byteenable,
  output soc_pkg::data_t ram_readdata
);
  import soc_pkg::*;

  data_t      mem [RAM_WORDS];
  ram_index_t idx;

  // word index from the byte address
  assign idx = address[9:2];

  always_ff @(posedge clock_50) begin
    if (ram_write) begin
      for (int b = 0; b < 4; b++) begin
        if (byteenable[b]) begin
          mem[idx][8*b +: 8] <= writedata[8*b +: 8];
        end
      end
    end
  end

  // registered read, word appears one edge after the pulse
  always_ff @(posedge clock_50) begin
    if (ram_read) begin
      ram_readdata <= mem[idx];
    end
  end

endmodule

// ==== io_regs.sv ====
`timescale 1ns/10ps

module io_regs (
  input  logic           clock_50,
  input  logic           rst_n,
  input  logic           io_read,
  input  logic           io_write,
  input  soc_pkg::addr_t address,
  input  soc_pkg::data_t writedata,
  input  soc_pkg::be_t   byteenable,
  input  soc_pkg::sw_t   sw,
  output soc_pkg::data_t io_readdata,
  output soc_pkg::led_t  ledr
);
  import soc_pkg::*;

  io_index_t idx;
  led_t      led_q;
  sw_t       sw_meta;
  sw_t       sw_sync;

  assign idx  = address[3:2];
  assign ledr = led_q;

  // switches are asynchronous to the bus clock
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  // led register, only the low three bytes exist
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      led_q <= '0;
    end else if (io_write && idx == IO_LED) begin
      if (byteenable[0]) begin
        led_q[7:0] <= writedata[7:0];
      end
      if (byteenable[1]) begin
        led_q[15:8] <= writedata[15:8];
      end
      if (byteenable[2]) begin
        led_q[17:16] <= writedata[17:16];
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (io_read) begin
      case (idx)
        IO_LED:  io_readdata <= {14'h0, led_q};
        IO_SW:   io_readdata <= {14'h0, sw_sync};
        // unused slots
        default: io_readdata <= '0;
      endcase
    end
  end

  a_io_exclusive: assert property (@(posedge clock_50) disable iff (!rst_n)
    !(io_read && io_write))
    else $error("io read and write pulses overlap");

endmodule

// ==== hex_monitor.sv ====
`timescale 1ns/10ps

module hex_monitor (
  input  logic           clock_50,
  input  logic           rst_n,
  input  logic           bus_start,
  input  logic           show_key,
  input  soc_pkg::addr_t address,
  output soc_pkg::seg_t  hex0,
  output soc_pkg::seg_t  hex1,
  output soc_pkg::seg_t  hex2,
  output soc_pkg::seg_t  hex3,
  output soc_pkg::seg_t  hex4,
  output soc_pkg::seg_t  hex5,
  output soc_pkg::seg_t  hex6,
  output soc_pkg::seg_t  hex7
);
  import soc_pkg::*;

  addr_t disp_q;

  // pattern bits are {g,f,e,d,c,b,a}, low lights a segment
  function automatic seg_t seg_of(input logic [3:0] n);
    seg_t s;
    case (n)
      4'h0: s = 7'b1000000;
      4'h1: s = 7'b1111001;
      4'h2: s = 7'b0100100;
      4'h3: s = 7'b0110000;
      4'h4: s = 7'b0011001;
      4'h5: s = 7'b0010010;
      4'h6: s = 7'b0000010;
      4'h7: s = 7'b1111000;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0010000;
      4'ha: s = 7'b0001000;
      4'hb: s = 7'b0000011;
      4'hc: s = 7'b1000110;
      4'hd: s = 7'b0100001;
      4'he: s = 7'b0000110;
      default: s = 7'b0001110;
    endcase
    return s;
  endfunction

  // key held means follow the bus, released means freeze
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      disp_q <= '0;
    end else if (bus_start && show_key) begin
      disp_q <= address;
    end
  end

  assign hex0 = seg_of(disp_q[3:0]);
  assign hex1 = seg_of(disp_q[7:4]);
  assign hex2 = seg_of(disp_q[11:8]);
  assign hex3 = seg_of(disp_q[15:12]);
  assign hex4 = seg_of(disp_q[19:16]);
  assign hex5 = seg_of(disp_q[23:20]);
  assign hex6 = seg_of(disp_q[27:24]);
  assign hex7 = seg_of(disp_q[31:28]);

endmodule

// ==== bus_controller.sv ====
`timescale 1ns/10ps

module bus_controller (
  input  logic           clock_50,
  input  logic           rst_n,
  input  soc_pkg::addr_t address,
  input  logic           read,
  input  logic           write,
  input  soc_pkg::data_t ram_readdata,
  input  soc_pkg::data_t io_readdata,
  output soc_pkg::data_t readdata,
  output logic           waitrequest,
  output logic           fault,
  output logic           bus_start,
  output logic           ram_read,
  output logic           ram_write,
  output logic           io_read,
  output logic           io_write
);
  import soc_pkg::*;

  bus_state_e state;
  cs_e        cs_now;
  cs_e        cs_q;
  logic       strobe;

  function automatic cs_e decode_cs(input addr_t a);
    cs_e cs;
    cs = cs_none;
    if ((a & ~RAM_MASK) == RAM_BASE) begin
      cs = cs_ram;
    end else if ((a & ~IO_MASK) == IO_BASE) begin
      cs = cs_io;
    end
    return cs;
  endfunction

  assign strobe      = read | write;
  assign cs_now      = decode_cs(address);
  // master is held off for every state but st_done
  assign waitrequest = strobe && (state != st_done);

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      cs_q      <= cs_none;
      bus_start <= 1'b0;
      ram_read  <= 1'b0;
      ram_write <= 1'b0;
      io_read   <= 1'b0;
      io_write  <= 1'b0;
      fault     <= 1'b0;
    end else begin
      // slave strobes last one cycle
      bus_start <= 1'b0;
      ram_read  <= 1'b0;
      ram_write <= 1'b0;
      io_read   <= 1'b0;
      io_write  <= 1'b0;
      case (state)
        st_idle: begin
          if (strobe) begin
            cs_q      <= cs_now;
            bus_start <= 1'b1;
            ram_read  <= read  && (cs_now == cs_ram);
            ram_write <= write && (cs_now == cs_ram);
            io_read   <= read  && (cs_now == cs_io);
            io_write  <= write && (cs_now == cs_io);
            // sticky until reset
            if (cs_now == cs_none) begin
              fault <= 1'b1;
            end
            state <= st_access;
          end
        end
        st_access: begin
          state <= st_capture;
        end
        st_capture: begin
          state <= st_done;
        end
        st_done: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // slave read data merges here, one edge after the slave registers it
  always_ff @(posedge clock_50) begin
    if (state == st_capture) begin
      if (!read) begin
        readdata <= '0;
      end else begin
        case (cs_q)
          cs_ram:  readdata <= ram_readdata;
          cs_io:   readdata <= io_readdata;
          default: readdata <= '0;
        endcase
      end
    end
  end

  a_single_strobe: assert property (@(posedge clock_50) disable iff (!rst_n)
    !(read && write))
    else $error("read and write raised together");

  a_one_slave_pulse: assert property (@(posedge clock_50) disable iff (!rst_n)
    $onehot0({ram_read, ram_write, io_read, io_write}))
    else $error("more than one slave strobe active");

endmodule

// ==== soc_core.sv ====
`timescale 1ns/10ps

module soc_core (
  input  logic           clock_50,
  input  logic           rst_n,
  input  soc_pkg::addr_t address,
  input  logic           read,
  input  logic           write,
  input  soc_pkg::data_t writedata,
  input  soc_pkg::be_t   byteenable,
  input  soc_pkg::sw_t   sw,
  input  logic           show_key,
  output soc_pkg::data_t readdata,
  output logic           waitrequest,
  output logic           fault,
  output soc_pkg::led_t  ledr,
  output soc_pkg::seg_t  hex0,
  output soc_pkg::seg_t  hex1,
  output soc_pkg::seg_t  hex2,
  output soc_pkg::seg_t  hex3,
  output soc_pkg::seg_t  hex4,
  output soc_pkg::seg_t  hex5,
  output soc_pkg::seg_t  hex6,
  output soc_pkg::seg_t  hex7
);
  import soc_pkg::*;

  data_t ram_readdata;
  data_t io_readdata;
  logic  bus_start;
  logic  ram_read;
  logic  ram_write;
  logic  io_read;
  logic  io_write;

  bus_controller bus_controller_i (
    .clock_50     (clock_50),
    .rst_n        (rst_n),
    .address      (address),
    .read         (read),
    .write        (write),
    .ram_readdata (ram_readdata),
    .io_readdata  (io_readdata),
    .readdata     (readdata),
    .waitrequest  (waitrequest),
    .fault        (fault),
    .bus_start    (bus_start),
    .ram_read     (ram_read),
    .ram_write    (ram_write),
    .io_read      (io_read),
    .io_write     (io_write)
  );

  scratch_ram scratch_ram_i (
    .clock_50     (clock_50),
    .ram_read     (ram_read),
    .ram_write    (ram_write),
    .address      (address),
    .writedata    (writedata),
    .byteenable   (byteenable),
    .ram_readdata (ram_readdata)
  );

  io_regs io_regs_i (
    .clock_50    (clock_50),
    .rst_n       (rst_n),
    .io_read     (io_read),
    .io_write    (io_write),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .sw          (sw),
    .io_readdata (io_readdata),
    .ledr        (ledr)
  );

  // address display on the eight digits
  hex_monitor hex_monitor_i (
    .clock_50  (clock_50),
    .rst_n     (rst_n),
    .bus_start (bus_start),
    .show_key  (show_key),
    .address   (address),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5),
    .hex6      (hex6),
    .hex7      (hex7)
  );

endmodule

// ==== tb_soc_core.sv ====
`timescale 1ns/10ps

module tb_soc_core;
  import soc_pkg::*;

  localparam logic [31:0] RANDOM_SW = 32'hffff_ffff;

  typedef struct packed {
    logic [7:0] op;
    addr_t      addr;
    data_t      wdata;
    be_t        be;
    logic [31:0] sw;
    logic       key;
    data_t      exp_rdata;
    logic       fault;
  } case_t;

  logic  clock_50;
  logic  rst_n;
  addr_t address;
  logic  read;
  logic  write;
  data_t writedata;
  be_t   byteenable;
  sw_t   sw;
  logic  show_key;
  data_t readdata;
  logic  waitrequest;
  logic  fault;
  led_t  ledr;
  seg_t  hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

  case_t cases[$];
  led_t  led_model;
  addr_t disp_model;
  int    errors = 0;
  int    cycles = 0;
  int    limit = 0;

  soc_core soc_core_i (
    .clock_50    (clock_50),
    .rst_n       (rst_n),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .sw          (sw),
    .show_key    (show_key),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .fault       (fault),
    .ledr        (ledr),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5),
    .hex6        (hex6),
    .hex7        (hex7)
  );

  always #20 clock_50 = ~clock_50;

  always @(posedge clock_50) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: bus accesses did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  // active-high {g,f,e,d,c,b,a} segments inverted for the board
  function automatic seg_t digit_pattern(input logic [3:0] d);
    logic [6:0] lit;
    case (d)
      4'h0: lit = 7'h3f;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5b;
      4'h3: lit = 7'h4f;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6d;
      4'h6: lit = 7'h7d;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h6f;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7c;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5e;
      4'he: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  task automatic check_outputs(input int n);
    logic [55:0] hex_all;
    logic [55:0] hex_exp;
    hex_all = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};
    for (int i = 0; i < 8; i++) begin
      hex_exp[7*i +: 7] = digit_pattern(disp_model[4*i +: 4]);
    end
    assert (ledr == led_model)
      else report_error($sformatf("case %0d ledr %h expected %h", n, ledr, led_model));
    assert (hex_all == hex_exp)
      else report_error($sformatf("case %0d digits %h expected %h", n, hex_all, hex_exp));
  endtask

  task automatic run_case(input int n, input case_t c);
    logic [31:0] rnd;
    sw_t         sw_val;
    data_t       exp_rd;
    int          edges;
    @(negedge clock_50);
    read = 1'b0;
    write = 1'b0;
    if (c.sw == RANDOM_SW) begin
      rnd = $urandom();
      sw_val = rnd[17:0];
      exp_rd = {14'h0, sw_val};
    end else begin
      sw_val = c.sw[17:0];
      exp_rd = c.exp_rdata;
    end
    sw = sw_val;
    show_key = c.key;
    // models track the state this access leaves behind
    if (c.op == "W" && (c.addr & ~32'hf) == IO_BASE && c.addr[3:2] == 2'd0) begin
      if (c.be[0]) begin
        led_model[7:0] = c.wdata[7:0];
      end
      if (c.be[1]) begin
        led_model[15:8] = c.wdata[15:8];
      end
      if (c.be[2]) begin
        led_model[17:16] = c.wdata[17:16];
      end
    end
    if (c.key) begin
      disp_model = c.addr;
    end
    // two idle cycles so the switch synchronizer settles
    @(negedge clock_50);
    @(negedge clock_50);
    address = c.addr;
    writedata = c.wdata;
    byteenable = c.be;
    read = (c.op == "R");
    write = (c.op == "W");
    #1;
    assert (waitrequest)
      else report_error($sformatf("case %0d waitrequest low before edge 1", n));
    edges = 0;
    do begin
      @(posedge clock_50);
      edges++;
      @(negedge clock_50);
      // fault is set on edge 1 and the digits and leds change on edge 2
      if (edges == 1) begin
        assert (fault == c.fault)
          else report_error($sformatf("case %0d fault %b after edge 1, expected %b",
                                      n, fault, c.fault));
      end
      if (edges == 2) begin
        check_outputs(n);
      end
    end while (waitrequest);
    assert (edges == 3)
      else report_error($sformatf("case %0d waitrequest fell after %0d edges", n, edges));
    if (c.op == "R") begin
      assert (readdata == exp_rd)
        else report_error($sformatf("case %0d readdata %h expected %h", n, readdata, exp_rd));
    end
    assert (fault == c.fault)
      else report_error($sformatf("case %0d fault %b expected %b", n, fault, c.fault));
    check_outputs(n);
    // completion edge
    @(posedge clock_50);
  endtask

  initial begin
    int          fd;
    int          cnt;
    string       line;
    case_t       c;
    logic [31:0] t_addr, t_wdata, t_be, t_sw, t_key, t_exp, t_fault;
    clock_50 = 1'b0;
    rst_n = 1'b0;
    address = '0;
    read = 1'b0;
    write = 1'b0;
    writedata = '0;
    byteenable = '0;
    sw = '0;
    show_key = 1'b0;
    led_model = '0;
    disp_model = '0;
    void'($urandom(32'h9ba6));
    fd = $fopen("soc_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open soc_cases.txt");
      $display("RESULT: FAIL");
      $fatal(1, "missing case file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 2 && line[0] != "#") begin
        cnt = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h",
                      t_addr, t_wdata, t_be, t_sw, t_key, t_exp, t_fault);
        if (cnt != 7) begin
          $display("malformed line in soc_cases.txt: %s", line);
          $display("RESULT: FAIL");
          $fatal(1, "bad case file");
        end
        c.op = line[0];
        c.addr = t_addr;
        c.wdata = t_wdata;
        c.be = t_be[3:0];
        c.sw = t_sw;
        c.key = t_key[0];
        c.exp_rdata = t_exp;
        c.fault = t_fault[0];
        cases.push_back(c);
      end
    end
    $fclose(fd);
    limit = 16 + 8 * cases.size() + 100;

    repeat (16) @(negedge clock_50);
    rst_n = 1'b1;
    @(negedge clock_50);
    assert (fault == 1'b0)
      else report_error("fault set after reset");
    check_outputs(0);

    for (int i = 0; i < cases.size(); i++) begin
      run_case(i + 1, cases[i]);
    end
    @(negedge clock_50);
    read = 1'b0;
    write = 1'b0;

    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== soc_cases.txt ====
# op addr wdata be sw key exp_rdata fault (hex, exp_rdata only checked on reads)
# sw ffffffff drives a random 18-bit value and the expected word is that value
W 00000000 12345678 f 00000 1 00000000 0
R 00000000 00000000 0 00000 1 12345678 0
W 00000004 cafef00d f 00000 1 00000000 0
W 00000004 aabbccdd 5 00000 1 00000000 0
R 00000004 00000000 0 00000 1 cabbf0dd 0
W 000003fc 0badc0de f 00000 0 00000000 0
W 000003fc ffffffff 8 00000 0 00000000 0
R 000003fc 00000000 0 00000 1 ffadc0de 0
R 00000000 00000000 0 00000 1 12345678 0
W 00010000 ffffffff f 00000 1 00000000 0
R 00010000 00000000 0 00000 1 0003ffff 0
W 00010000 00012345 2 00000 0 00000000 0
R 00010000 00000000 0 00000 1 000323ff 0
R 00010004 00000000 0 2a5a5 1 0002a5a5 0
R 00010004 00000000 0 ffffffff 1 00000000 0
R 00010004 00000000 0 ffffffff 0 00000000 0
W 00010008 ffffffff f 00000 1 00000000 0
R 00010008 00000000 0 00000 1 00000000 0
R 0001000c 00000000 0 00000 1 00000000 0
R 00020000 00000000 0 00000 1 00000000 1
R 00000004 00000000 0 00000 0 cabbf0dd 1
W 00000400 11111111 f 00000 0 00000000 1
R 00010000 00000000 0 00000 1 000323ff 1
R 00000000 00000000 0 00000 1 12345678 1

// ==== compile.f ====
soc_pkg.sv
scratch_ram.sv
io_regs.sv
hex_monitor.sv
bus_controller.sv
soc_core.sv
tb_soc_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the soc_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_soc_core -o sim_soc \
  && (./obj_dir/sim_soc | tee sim.log) \
  && ! grep -q "RESULT: FAIL" sim.log \
  && grep -q "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
